/* bench/coherenceBench.sv */
// ==================================================
// testbench for the two-core coherent memory system
// directed coherence tests, LCG random traffic,
// flat memory model, watchdog and summary
// ==================================================
`timescale 1ns/100ps
`include "coherence_macros.svh"

module coherenceBench import coherencePkg::*; ();

   localparam logic [31:0] SEED = 32'hb26a_2893;
   localparam int RANDOM_DATA  = 300;
   localparam int RANDOM_FETCH = 30;
   // request counts of tests 2 to 6
   localparam int REQUESTS    = 2 + 2 + 4 + 8 + RANDOM_DATA + 2 * RANDOM_FETCH;
   localparam int CYCLE_LIMIT = REQUESTS * 40;
   localparam addr_t POOL_BASE  = 8'h20;
   localparam int    POOL_WORDS = 12;

   logic     CLK;
   logic     nRST;
   cpuReq_t  cpuReq0;
   cpuReq_t  cpuReq1;
   cpuResp_t cpuResp0;
   cpuResp_t cpuResp1;

   cpuReq_t     reqs [2];
   cpuResp_t    resps [2];
   word_t       model [`RAM_DEPTH];
   logic [31:0] rngState [2];

   // cycles the last data access of each core spent with dwait high
   int waitCount [2];

   int errors = 0;
   int testsRun = 0;
   int testsFailing = 0;
   int cycles = 0;

   coherenceTop dut0 (
      .CLK(CLK), .nRST(nRST), .cpuReq0(cpuReq0), .cpuReq1(cpuReq1),
      .cpuResp0(cpuResp0), .cpuResp1(cpuResp1)
   );

   assign cpuReq0  = reqs[0];
   assign cpuReq1  = reqs[1];
   assign resps[0] = cpuResp0;
   assign resps[1] = cpuResp1;

   initial begin
      CLK = 1'b0;
      forever #50 CLK = ~CLK;
   end

   always @(posedge CLK) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, a request never completed", cycles);
         $display("tests failed");
         $finish;
      end
   end

   // reset contents of every RAM word
   function automatic word_t initWord(input addr_t addr);
      return word_t'(addr) ^ `RAM_INIT;
   endfunction

   function automatic logic [31:0] lcgStep(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // upper LCG bits are the better ones and come out low
   function automatic logic [31:0] nextRand(input logic core);
      rngState[core] = lcgStep(rngState[core]);
      return {rngState[core][15:0], rngState[core][31:16]};
   endfunction

   task automatic checkWord(input string name, input word_t got, input word_t expected);
      assert (got === expected) else begin
         $display("Fail %s: got %h expected %h", name, got, expected);
         errors++;
      end
   endtask

   task automatic idleCheck(input logic core);
      checkWord($sformatf("cpuResp%0d.dwait", core), word_t'(resps[core].dwait), '0);
      checkWord($sformatf("cpuResp%0d.iwait", core), word_t'(resps[core].iwait), '0);
   endtask

   task automatic dataAccess(input logic core, input logic write, input addr_t addr,
                             input word_t value);
      @(posedge CLK);
      reqs[core].dREN   <= ~write;
      reqs[core].dWEN   <= write;
      reqs[core].daddr  <= addr;
      reqs[core].dstore <= value;
      waitCount[core] = 0;
      @(negedge CLK);
      while (resps[core].dwait) begin
         waitCount[core]++;
         @(negedge CLK);
      end
      if (!write) begin
         checkWord($sformatf("cpuResp%0d.dload", core), resps[core].dload, model[addr]);
      end
      // completing edge
      @(posedge CLK);
      if (write) begin
         model[addr] = value;
      end
      reqs[core].dREN <= 1'b0;
      reqs[core].dWEN <= 1'b0;
   endtask

   task automatic fetchWord(input logic core, input addr_t addr);
      @(posedge CLK);
      reqs[core].iREN  <= 1'b1;
      reqs[core].iaddr <= addr;
      @(negedge CLK);
      while (resps[core].iwait) begin
         @(negedge CLK);
      end
      checkWord($sformatf("cpuResp%0d.iload", core), resps[core].iload, initWord(addr));
      @(posedge CLK);
      reqs[core].iREN <= 1'b0;
   endtask

   task automatic randomTraffic(input logic core);
      int          dataLeft;
      int          fetchLeft;
      logic [31:0] r;
      addr_t       addr;
      dataLeft  = RANDOM_DATA / 2;
      fetchLeft = RANDOM_FETCH;
      while (dataLeft > 0 || fetchLeft > 0) begin
         r = nextRand(core);
         if (fetchLeft > 0 && (dataLeft == 0 || r[3:0] < 4'd2)) begin
            // instructions live in the upper half only
            fetchWord(core, {1'b1, r[14:8]});
            fetchLeft--;
         end else begin
            addr = POOL_BASE + addr_t'(int'(r[15:8]) % POOL_WORDS);
            dataAccess(core, r[4], addr, nextRand(core));
            dataLeft--;
         end
      end
   endtask

   task automatic finishTest(input int num, input string name, input int errorsAtStart);
      testsRun++;
      if (errors == errorsAtStart) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         testsFailing++;
         $display("test %0d %s: %0d check errors", num, name, errors - errorsAtStart);
      end
   endtask

   initial begin
      int mark;
      nRST    <= 1'b0;
      reqs[0] <= '0;
      reqs[1] <= '0;
      rngState[0] = SEED;
      rngState[1] = ~SEED;
      for (int i = 0; i < `RAM_DEPTH; i++) begin
         model[addr_t'(i)] = initWord(addr_t'(i));
      end
      repeat (16) @(posedge CLK);
      nRST <= 1'b1;

      mark = errors;
      @(negedge CLK);
      idleCheck(1'b0);
      idleCheck(1'b1);
      finishTest(1, "idle after reset", mark);

      // miss fill then hit path
      mark = errors;
      dataAccess(1'b0, 1'b1, 8'h05, 32'h1111_2222);
      dataAccess(1'b0, 1'b0, 8'h05, '0);
      // a modified line answers in the same cycle
      assert (waitCount[0] == 0) else begin
         $display("read of a modified line in cache 0 waited %0d cycles instead of hitting",
                  waitCount[0]);
         errors++;
      end
      finishTest(2, "write and read back", mark);

      // dirty copy in cache 0 written back before core 1 reads
      mark = errors;
      dataAccess(1'b0, 1'b1, 8'h0A, 32'h3333_4444);
      dataAccess(1'b1, 1'b0, 8'h0A, '0);
      finishTest(3, "dirty writeback", mark);

      mark = errors;
      dataAccess(1'b0, 1'b0, 8'h13, '0);
      dataAccess(1'b1, 1'b0, 8'h13, '0);
      dataAccess(1'b1, 1'b1, 8'h13, 32'hC0DE_0004);
      dataAccess(1'b0, 1'b0, 8'h13, '0);
      finishTest(4, "invalidation", mark);

      // all on line 0
      mark = errors;
      for (int k = 0; k < 4; k++) begin
         dataAccess(1'b0, 1'b1, 8'h40 + addr_t'(4 * k), 32'h5000_0000 + word_t'(k));
      end
      for (int k = 0; k < 4; k++) begin
         dataAccess(1'b0, 1'b0, 8'h40 + addr_t'(4 * k), '0);
      end
      finishTest(5, "victim writeback", mark);

      mark = errors;
      fork
         randomTraffic(1'b0);
         randomTraffic(1'b1);
      join
      finishTest(6, "random traffic", mark);

      $display("%0d tests run, %0d passing, %0d failing, %0d check errors",
               testsRun, testsRun - testsFailing, testsFailing, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* build.f */
+incdir+include
design/coherencePkg.sv
design/ramModel.sv
design/snoopCache.sv
design/memoryControl.sv
design/coherenceTop.sv
bench/coherenceBench.sv

/* design/coherencePkg.sv */
// ================================================
// shared types of the coherent memory subsystem
// RAM and line states, core, bus, snoop and RAM
// request and response structs
// ================================================
`include "coherence_macros.svh"

package coherencePkg;

   typedef logic [`WORD_WIDTH-1:0] word_t;
   typedef logic [`ADDR_WIDTH-1:0] addr_t;

   typedef enum logic [1:0] {FREE, BUSY, ACCESS} ramState_t;

   typedef enum logic [1:0] {INVALID, SHARED, MODIFIED} lineState_t;

   typedef struct packed {
      logic  dREN;
      logic  dWEN;
      addr_t daddr;
      word_t dstore;
      logic  iREN;
      addr_t iaddr;
   } cpuReq_t;

   typedef struct packed {
      logic  dwait;
      word_t dload;
      logic  iwait;
      word_t iload;
   } cpuResp_t;

   // dWEN on the bus is a read for ownership
   typedef struct packed {
      logic  dREN;
      logic  dWEN;
      logic  wbEn;
      addr_t daddr;
      word_t dstore;
   } busReq_t;

   typedef struct packed {
      logic  dwait;
      word_t dload;
   } busResp_t;

   typedef struct packed {
      logic  snoopValid;
      logic  snoopInv;
      addr_t snoopAddr;
   } snoopReq_t;

   typedef struct packed {
      logic  hit;
      logic  dirty;
      word_t data;
   } snoopResp_t;

   typedef struct packed {
      logic  ramREN;
      logic  ramWEN;
      addr_t ramaddr;
      word_t ramstore;
   } ramReq_t;

endpackage

/* design/coherenceTop.sv */
// ================================================
// two-core coherent memory subsystem
// two data caches, memory controller and RAM
// ================================================
`timescale 1ns/100ps

module coherenceTop import coherencePkg::*; (
   input  logic     CLK,
   input  logic     nRST,
   input  cpuReq_t  cpuReq0,
   input  cpuReq_t  cpuReq1,
   output cpuResp_t cpuResp0,
   output cpuResp_t cpuResp1
);

   busReq_t    busReq0;
   busReq_t    busReq1;
   busResp_t   busResp0;
   busResp_t   busResp1;
   snoopReq_t  snoopReq0;
   snoopReq_t  snoopReq1;
   snoopResp_t snoopResp0;
   snoopResp_t snoopResp1;
   ramReq_t    ramReq;
   word_t      ramload;
   ramState_t  ramState;

   logic  dwait0;
   logic  dwait1;
   logic  iwait0;
   logic  iwait1;
   word_t dload0;
   word_t dload1;
   word_t iload0;
   word_t iload1;

   snoopCache cache0 (
      .CLK(CLK), .nRST(nRST), .cpuData(cpuReq0), .busResp(busResp0),
      .snoopReq(snoopReq0), .dwait(dwait0), .dload(dload0),
      .busReq(busReq0), .snoopResp(snoopResp0)
   );

   snoopCache cache1 (
      .CLK(CLK), .nRST(nRST), .cpuData(cpuReq1), .busResp(busResp1),
      .snoopReq(snoopReq1), .dwait(dwait1), .dload(dload1),
      .busReq(busReq1), .snoopResp(snoopResp1)
   );

   // instruction fetches bypass the caches
   memoryControl memCtrl (
      .CLK(CLK), .nRST(nRST), .busReq0(busReq0), .busReq1(busReq1),
      .snoopResp0(snoopResp0), .snoopResp1(snoopResp1),
      .ifetch0(cpuReq0), .ifetch1(cpuReq1), .ramload(ramload), .ramState(ramState),
      .busResp0(busResp0), .busResp1(busResp1),
      .snoopReq0(snoopReq0), .snoopReq1(snoopReq1),
      .iwait0(iwait0), .iwait1(iwait1), .iload0(iload0), .iload1(iload1),
      .ramReq(ramReq)
   );

   ramModel ram (
      .CLK(CLK), .nRST(nRST), .ramReq(ramReq), .ramload(ramload), .ramState(ramState)
   );

   assign cpuResp0.dwait = dwait0;
   assign cpuResp0.dload = dload0;
   assign cpuResp0.iwait = iwait0;
   assign cpuResp0.iload = iload0;
   assign cpuResp1.dwait = dwait1;
   assign cpuResp1.dload = dload1;
   assign cpuResp1.iwait = iwait1;
   assign cpuResp1.iload = iload1;

endmodule

/* design/memoryControl.sv */
// ================================================
// memory controller for two snooping caches
// data arbitration, MSI snoop and writeback,
// uncached instruction fetch, RAM access
// ================================================
`timescale 1ns/100ps

module memoryControl import coherencePkg::*; (
   input  logic       CLK,
   input  logic       nRST,
   input  busReq_t    busReq0,
   input  busReq_t    busReq1,
   input  snoopResp_t snoopResp0,
   input  snoopResp_t snoopResp1,
   input  cpuReq_t    ifetch0,
   input  cpuReq_t    ifetch1,
   input  word_t      ramload,
   input  ramState_t  ramState,
   output busResp_t   busResp0,
   output busResp_t   busResp1,
   output snoopReq_t  snoopReq0,
   output snoopReq_t  snoopReq1,
   output logic       iwait0,
   output logic       iwait1,
   output word_t      iload0,
   output word_t      iload1,
   output ramReq_t    ramReq
);

   typedef enum logic [2:0] {idle, snoop, writeBack, memAccess, fetch} ctrlState_t;

   ctrlState_t state;
   ctrlState_t nextState;

   // cache being served and the one being snooped
   logic owner;
   logic nextOwner;
   logic other;
   logic fetchOwner;
   logic nextFetchOwner;
   logic lastGrant;

   // dirty data captured in the snoop cycle
   word_t wbData;

   busReq_t    busReqs [2];
   snoopResp_t snoopResps [2];
   snoopReq_t  snoopReqs [2];
   cpuReq_t    ifetches [2];

   logic [1:0] dataPending;
   logic [1:0] dataDone;
   logic [1:0] fetchDone;
   logic       ramDone;

   assign busReqs[0]    = busReq0;
   assign busReqs[1]    = busReq1;
   assign snoopResps[0] = snoopResp0;
   assign snoopResps[1] = snoopResp1;
   assign ifetches[0]   = ifetch0;
   assign ifetches[1]   = ifetch1;

   assign dataPending[0] = busReq0.dREN | busReq0.dWEN | busReq0.wbEn;
   assign dataPending[1] = busReq1.dREN | busReq1.dWEN | busReq1.wbEn;

   assign other   = ~owner;
   assign ramDone = (ramState == ACCESS);

   always_comb begin
      nextState      = state;
      nextOwner      = owner;
      nextFetchOwner = fetchOwner;
      case (state)
         idle: begin
            if (|dataPending) begin
               // alternate when both caches ask
               if (dataPending[0] && dataPending[1]) begin
                  nextOwner = ~lastGrant;
               end else begin
                  nextOwner = dataPending[1];
               end
               // a victim writeback needs no snoop, the line is owned
               if (busReqs[nextOwner].wbEn) begin
                  nextState = memAccess;
               end else begin
                  nextState = snoop;
               end
            end else if (ifetch0.iREN) begin
               nextFetchOwner = 1'b0;
               nextState      = fetch;
            end else if (ifetch1.iREN) begin
               nextFetchOwner = 1'b1;
               nextState      = fetch;
            end
         end
         snoop: begin
            if (snoopResps[other].dirty) begin
               nextState = writeBack;
            end else begin
               nextState = memAccess;
            end
         end
         writeBack: begin
            if (ramDone) begin
               nextState = memAccess;
            end
         end
         memAccess: begin
            if (ramDone) begin
               nextState = idle;
            end
         end
         fetch: begin
            if (ramDone) begin
               nextState = idle;
            end
         end
         default: begin
            nextState = idle;
         end
      endcase
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state      <= idle;
         owner      <= 1'b0;
         fetchOwner <= 1'b0;
         lastGrant  <= 1'b1;
      end else begin
         state      <= nextState;
         owner      <= nextOwner;
         fetchOwner <= nextFetchOwner;
         if (state == idle && |dataPending) begin
            lastGrant <= nextOwner;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (state == snoop) begin
         wbData <= snoopResps[other].data;
      end
   end

   always_comb begin
      ramReq       = '0;
      snoopReqs[0] = '0;
      snoopReqs[1] = '0;
      case (state)
         snoop: begin
            snoopReqs[other].snoopValid = 1'b1;
            snoopReqs[other].snoopInv   = busReqs[owner].dWEN;
            snoopReqs[other].snoopAddr  = busReqs[owner].daddr;
         end
         writeBack: begin
            // other cache's modified copy goes out first
            ramReq.ramWEN   = 1'b1;
            ramReq.ramaddr  = busReqs[owner].daddr;
            ramReq.ramstore = wbData;
         end
         memAccess: begin
            ramReq.ramWEN   = busReqs[owner].wbEn;
            ramReq.ramREN   = ~busReqs[owner].wbEn;
            ramReq.ramaddr  = busReqs[owner].daddr;
            ramReq.ramstore = busReqs[owner].dstore;
         end
         fetch: begin
            ramReq.ramREN  = 1'b1;
            ramReq.ramaddr = ifetches[fetchOwner].iaddr;
         end
         default: begin
            ramReq = '0;
         end
      endcase
   end

   assign snoopReq0 = snoopReqs[0];
   assign snoopReq1 = snoopReqs[1];

   assign dataDone[0]  = (state == memAccess) && (owner == 1'b0) && ramDone;
   assign dataDone[1]  = (state == memAccess) && (owner == 1'b1) && ramDone;
   assign fetchDone[0] = (state == fetch) && (fetchOwner == 1'b0) && ramDone;
   assign fetchDone[1] = (state == fetch) && (fetchOwner == 1'b1) && ramDone;

   // losers just see wait held high
   assign busResp0.dwait = dataPending[0] & ~dataDone[0];
   assign busResp1.dwait = dataPending[1] & ~dataDone[1];
   assign busResp0.dload = ramload;
   assign busResp1.dload = ramload;

   assign iwait0 = ifetch0.iREN & ~fetchDone[0];
   assign iwait1 = ifetch1.iREN & ~fetchDone[1];
   assign iload0 = ramload;
   assign iload1 = ramload;

endmodule

/* design/ramModel.sv */
// ================================================
// word-addressed RAM with fixed access latency
// reports FREE, BUSY or ACCESS each cycle
// ================================================
`timescale 1ns/100ps
`include "coherence_macros.svh"

module ramModel import coherencePkg::*; (
   input  logic      CLK,
   input  logic      nRST,
   input  ramReq_t   ramReq,
   output word_t     ramload,
   output ramState_t ramState
);

   localparam int CNT_W = $clog2(`RAM_LATENCY + 1);

   word_t            mem [`RAM_DEPTH];
   logic [CNT_W-1:0] latency;
   logic             active;

   assign active = ramReq.ramREN | ramReq.ramWEN;

   always_comb begin
      if (!active) begin
         ramState = FREE;
      end else if (latency == CNT_W'(`RAM_LATENCY)) begin
         ramState = ACCESS;
      end else begin
         ramState = BUSY;
      end
   end

   // restarts after each ACCESS so back-to-back requests count afresh
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         latency <= '0;
      end else if (!active || ramState == ACCESS) begin
         latency <= '0;
      end else begin
         latency <= latency + 1'b1;
      end
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < `RAM_DEPTH; i++) begin
            mem[i] <= word_t'(i) ^ `RAM_INIT;
         end
      end else if (ramReq.ramWEN && ramState == ACCESS) begin
         mem[ramReq.ramaddr] <= ramReq.ramstore;
      end
   end

   // sampled by the controller in the ACCESS cycle
   assign ramload = mem[ramReq.ramaddr];

endmodule

/* design/snoopCache.sv */
// ================================================
// direct-mapped write-back data cache
// MSI line states, victim writeback, snoop port
// ================================================
`timescale 1ns/100ps
`include "coherence_macros.svh"

module snoopCache import coherencePkg::*; (
   input  logic       CLK,
   input  logic       nRST,
   input  cpuReq_t    cpuData,
   input  busResp_t   busResp,
   input  snoopReq_t  snoopReq,
   output logic       dwait,
   output word_t      dload,
   output busReq_t    busReq,
   output snoopResp_t snoopResp
);

   localparam int IDX_W = $clog2(`CACHE_LINES);
   localparam int TAG_W = `ADDR_WIDTH - IDX_W;

   typedef enum logic [1:0] {LOOKUP, VICTIM, FILL} missPhase_t;

   logic [TAG_W-1:0] tags [`CACHE_LINES];
   word_t            lineData [`CACHE_LINES];
   lineState_t       states [`CACHE_LINES];

   logic [IDX_W-1:0] idx;
   logic [IDX_W-1:0] snoopIdx;
   logic [TAG_W-1:0] tag;
   logic [TAG_W-1:0] snoopTag;

   logic       cpuReq;
   logic       tagMatch;
   logic       hitOk;
   logic       snoopClash;
   logic       hitDone;
   logic       busDone;
   logic       snoopHit;
   missPhase_t phase;

   assign idx    = cpuData.daddr[IDX_W-1:0];
   assign tag    = cpuData.daddr[`ADDR_WIDTH-1:IDX_W];
   assign cpuReq = cpuData.dREN | cpuData.dWEN;

   // writes need the line in MODIFIED
   assign tagMatch = (states[idx] != INVALID) && (tags[idx] == tag);
   assign hitOk    = tagMatch && (cpuData.dREN || states[idx] == MODIFIED);

   // hold a hit back while the same line is being snooped
   assign snoopClash = snoopReq.snoopValid && (snoopIdx == idx);
   assign hitDone    = cpuReq && hitOk && !snoopClash;
   assign busDone    = ~busResp.dwait;

   // miss sequencing, a modified victim goes out before the fill
   always_comb begin
      if (!cpuReq || hitOk) begin
         phase = LOOKUP;
      end else if (states[idx] == MODIFIED) begin
         phase = VICTIM;
      end else begin
         phase = FILL;
      end
   end

   always_comb begin
      busReq        = '0;
      busReq.daddr  = cpuData.daddr;
      busReq.dstore = lineData[idx];
      case (phase)
         VICTIM: begin
            busReq.wbEn  = 1'b1;
            busReq.daddr = {tags[idx], idx};
         end
         FILL: begin
            busReq.dREN = cpuData.dREN;
            busReq.dWEN = cpuData.dWEN;
         end
         default: begin
            busReq.wbEn = 1'b0;
         end
      endcase
   end

   assign dwait = cpuReq && !(hitDone || (phase == FILL && busDone));
   assign dload = (phase == FILL) ? busResp.dload : lineData[idx];

   assign snoopIdx = snoopReq.snoopAddr[IDX_W-1:0];
   assign snoopTag = snoopReq.snoopAddr[`ADDR_WIDTH-1:IDX_W];
   assign snoopHit = snoopReq.snoopValid && (states[snoopIdx] != INVALID) &&
                     (tags[snoopIdx] == snoopTag);

   assign snoopResp.hit   = snoopHit;
   assign snoopResp.dirty = snoopHit && (states[snoopIdx] == MODIFIED);
   assign snoopResp.data  = lineData[snoopIdx];

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < `CACHE_LINES; i++) begin
            states[i] <= INVALID;
         end
      end else begin
         if (phase == VICTIM && busDone) begin
            states[idx] <= INVALID;
         end else if (phase == FILL && busDone) begin
            states[idx] <= cpuData.dWEN ? MODIFIED : SHARED;
         end
         // snoops never land on the line a hit completes
         if (snoopHit) begin
            if (snoopReq.snoopInv) begin
               states[snoopIdx] <= INVALID;
            end else if (states[snoopIdx] == MODIFIED) begin
               states[snoopIdx] <= SHARED;
            end
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (phase == FILL && busDone) begin
         tags[idx]     <= tag;
         lineData[idx] <= cpuData.dWEN ? cpuData.dstore : busResp.dload;
      end else if (hitDone && cpuData.dWEN) begin
         lineData[idx] <= cpuData.dstore;
      end
   end

endmodule

/* include/coherence_macros.svh */
// ================================================
// word and address widths, cache geometry
// RAM depth, access latency and reset pattern
// ================================================
`ifndef COHERENCE_MACROS_SVH
`define COHERENCE_MACROS_SVH

// data word and word address
`define WORD_WIDTH 32
`define ADDR_WIDTH 8

// one word per line, index from low address bits
`define CACHE_LINES 4

`define RAM_DEPTH (1 << `ADDR_WIDTH)

// start of an access to its ACCESS cycle
`define RAM_LATENCY 3

// each word resets to its address xor this
`define RAM_INIT 32'hA5A5_0000

`endif

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/100ps -f build.f \
   --top-module coherenceBench --Mdir obj_dir -o coherenceSim
./obj_dir/coherenceSim | tee sim.log
if grep -qx "all tests passed" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
